/* include/udp_arb_settings.svh */
// build-time settings for the UDP transmit arbiter
// source count, payload widths and arbitration mode
`ifndef UDP_ARB_SETTINGS_SVH
`define UDP_ARB_SETTINGS_SVH

// number of upstream UDP sources
`define UDP_ARB_S_COUNT 2
`define UDP_ARB_DATA_WIDTH 8
// user bit marks a bad frame
`define UDP_ARB_USER_WIDTH 1
// 1 selects round-robin and 0 fixed priority with source 0 highest
`define UDP_ARB_ROUND_ROBIN 1

`endif

/* rtl/axis_if.sv */
// AXI-stream payload interface
// data, user and last with the valid/ready handshake

`timescale 1ns/1ps
`default_nettype none

`include "udp_arb_settings.svh"

interface axis_if;
    logic [`UDP_ARB_DATA_WIDTH-1:0] tdata;
    logic [`UDP_ARB_USER_WIDTH-1:0] tuser;
    logic                           tlast;
    logic                           tvalid;
    logic                           tready;

    modport source (
        output tdata, tuser, tlast, tvalid,
        input  tready
    );

    modport sink (
        input  tdata, tuser, tlast, tvalid,
        output tready
    );
endinterface

`default_nettype wire

/* rtl/udp_arb_mux.sv */
// header and payload steering for the UDP transmit arbiter
// forwards the granted source's header, then its payload up to tlast
// frame_done pulses when the last beat is accepted

`timescale 1ns/1ps
`default_nettype none

`include "udp_arb_settings.svh"

module udp_arb_mux (
    input  var logic                                      clk,
    input  var logic                                      reset,

    input  var logic                                      grant_valid,
    input  var udp_tx_pkg::src_idx_t                      grant_idx,

    input  var logic [`UDP_ARB_S_COUNT-1:0]               s_hdr_valid,
    output var logic [`UDP_ARB_S_COUNT-1:0]               s_hdr_ready,
    input  var udp_tx_pkg::udp_tx_hdr_t [`UDP_ARB_S_COUNT-1:0] s_hdr,
    axis_if.sink                                          s_axis [`UDP_ARB_S_COUNT-1:0],

    output var logic                                      m_hdr_valid,
    input  var logic                                      m_hdr_ready,
    output var udp_tx_pkg::udp_tx_hdr_t                   m_hdr,
    axis_if.source                                        m_axis,

    output var logic                                      frame_done
);
    logic [`UDP_ARB_S_COUNT-1:0][`UDP_ARB_DATA_WIDTH-1:0] src_tdata;
    logic [`UDP_ARB_S_COUNT-1:0][`UDP_ARB_USER_WIDTH-1:0] src_tuser;
    logic [`UDP_ARB_S_COUNT-1:0]                          src_tlast;
    logic [`UDP_ARB_S_COUNT-1:0]                          src_tvalid;

    logic hdr_sent;
    logic hdr_open;
    logic pay_open;
    logic pay_valid;

    assign hdr_open = grant_valid && !hdr_sent;
    assign pay_open = grant_valid && hdr_sent;

    // header stage
    assign m_hdr_valid = hdr_open && s_hdr_valid[grant_idx];
    assign m_hdr = s_hdr[grant_idx];

    always_comb begin
        for (int i = 0; i < `UDP_ARB_S_COUNT; i++) begin
            s_hdr_ready[i] = hdr_open && (grant_idx == udp_tx_pkg::src_idx_t'(i))
                && m_hdr_ready;
        end
    end

    // interface arrays only take constant indices, so flatten them first
    for (genvar i = 0; i < `UDP_ARB_S_COUNT; i++) begin : g_src
        assign src_tdata[i] = s_axis[i].tdata;
        assign src_tuser[i] = s_axis[i].tuser;
        assign src_tlast[i] = s_axis[i].tlast;
        assign src_tvalid[i] = s_axis[i].tvalid;
        assign s_axis[i].tready = pay_open && (grant_idx == udp_tx_pkg::src_idx_t'(i))
            && m_axis.tready;
    end

    // payload stage
    assign pay_valid = pay_open && src_tvalid[grant_idx];

    assign m_axis.tvalid = pay_valid;
    assign m_axis.tdata = src_tdata[grant_idx];
    assign m_axis.tuser = src_tuser[grant_idx];
    assign m_axis.tlast = src_tlast[grant_idx];

    assign frame_done = pay_valid && m_axis.tready && src_tlast[grant_idx];

    // payload stays closed until this grant's header has gone out
    always_ff @(posedge clk) begin
        if (reset) begin
            hdr_sent <= 1'b0;
        end else if (frame_done) begin
            hdr_sent <= 1'b0;
        end else if (m_hdr_valid && m_hdr_ready) begin
            hdr_sent <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/udp_arb_select.sv */
// grant decoder for the UDP transmit arbiter
// picks one requesting source and holds it until the frame ends

`timescale 1ns/1ps
`default_nettype none

`include "udp_arb_settings.svh"

module udp_arb_select (
    input  var logic                           clk,
    input  var logic                           reset,

    input  var logic [`UDP_ARB_S_COUNT-1:0]    hdr_req,
    input  var logic                           frame_done,

    output var logic                           grant_valid,
    output var udp_tx_pkg::src_idx_t           grant_idx
);
    logic                 pick_valid;
    udp_tx_pkg::src_idx_t pick_idx;

    // search starts after the last winner in round-robin mode, at source 0 otherwise
    always_comb begin
        int base;
        int cand;
        base = (`UDP_ARB_ROUND_ROBIN != 0) ? int'(grant_idx) + 1 : 0;
        pick_valid = |hdr_req;
        pick_idx = grant_idx;
        // walk backwards so the nearest candidate is assigned last
        for (int i = `UDP_ARB_S_COUNT - 1; i >= 0; i--) begin
            cand = (base + i) % `UDP_ARB_S_COUNT;
            if (hdr_req[cand]) begin
                pick_idx = udp_tx_pkg::src_idx_t'(cand);
            end
        end
    end

    // grant_idx keeps the last winner after release
    always_ff @(posedge clk) begin
        if (reset) begin
            grant_valid <= 1'b0;
            grant_idx <= udp_tx_pkg::src_idx_t'(`UDP_ARB_S_COUNT - 1);
        end else begin
            if (grant_valid) begin
                if (frame_done) begin
                    grant_valid <= 1'b0;
                end
            end else if (pick_valid) begin
                grant_valid <= 1'b1;
                grant_idx <= pick_idx;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/udp_axis_skid.sv */
// two-entry skid buffer for the output payload stream
// input ready is registered, output follows an accepted beat by one cycle

`timescale 1ns/1ps
`default_nettype none

`include "udp_arb_settings.svh"

module udp_axis_skid (
    input var logic clk,
    input var logic reset,

    axis_if.sink    s_axis,
    axis_if.source  m_axis
);
    localparam int WORD_W = `UDP_ARB_DATA_WIDTH + `UDP_ARB_USER_WIDTH + 1;

    logic [WORD_W-1:0] mem [2];
    logic [WORD_W-1:0] out_word;
    logic [1:0]        count;
    logic [1:0]        count_next;
    logic              wr_ptr;
    logic              rd_ptr;
    logic              s_ready_reg;
    logic              push;
    logic              pop;

    assign push = s_axis.tvalid && s_ready_reg;
    assign pop = (count != 2'd0) && m_axis.tready;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 2'd1;
        end else if (pop && !push) begin
            count_next = count - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            s_ready_reg <= 1'b0;
        end else begin
            count <= count_next;
            s_ready_reg <= (count_next != 2'd2);
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {s_axis.tdata, s_axis.tuser, s_axis.tlast};
        end
    end

    assign s_axis.tready = s_ready_reg;

    assign out_word = mem[rd_ptr];
    assign m_axis.tvalid = (count != 2'd0);
    assign m_axis.tdata = out_word[WORD_W-1 -: `UDP_ARB_DATA_WIDTH];
    assign m_axis.tuser = out_word[`UDP_ARB_USER_WIDTH:1];
    assign m_axis.tlast = out_word[0];

endmodule

`default_nettype wire

/* rtl/udp_tx_arb_top.sv */
// top level of the UDP transmit arbiter
// plain per-source ports mapped onto the internal payload interfaces
// grant decoder, steering mux and output skid buffer

`timescale 1ns/1ps
`default_nettype none

`include "udp_arb_settings.svh"

module udp_tx_arb_top (
    input  var logic                                                  clk,
    input  var logic                                                  reset,

    input  var logic [`UDP_ARB_S_COUNT-1:0]                           s_hdr_valid,
    output var logic [`UDP_ARB_S_COUNT-1:0]                           s_hdr_ready,
    input  var udp_tx_pkg::udp_tx_hdr_t [`UDP_ARB_S_COUNT-1:0]        s_hdr,
    input  var logic [`UDP_ARB_S_COUNT-1:0][`UDP_ARB_DATA_WIDTH-1:0]  s_axis_tdata,
    input  var logic [`UDP_ARB_S_COUNT-1:0][`UDP_ARB_USER_WIDTH-1:0]  s_axis_tuser,
    input  var logic [`UDP_ARB_S_COUNT-1:0]                           s_axis_tlast,
    input  var logic [`UDP_ARB_S_COUNT-1:0]                           s_axis_tvalid,
    output var logic [`UDP_ARB_S_COUNT-1:0]                           s_axis_tready,

    output var logic                                                  m_hdr_valid,
    input  var logic                                                  m_hdr_ready,
    output var udp_tx_pkg::udp_tx_hdr_t                               m_hdr,
    output var logic [`UDP_ARB_DATA_WIDTH-1:0]                        m_axis_tdata,
    output var logic [`UDP_ARB_USER_WIDTH-1:0]                        m_axis_tuser,
    output var logic                                                  m_axis_tlast,
    output var logic                                                  m_axis_tvalid,
    input  var logic                                                  m_axis_tready
);
    logic                 grant_valid;
    udp_tx_pkg::src_idx_t grant_idx;
    logic                 frame_done;
    logic                 mux_hdr_valid;
    logic                 mux_hdr_ready;

    axis_if s_axis_if [`UDP_ARB_S_COUNT-1:0] ();
    axis_if mux_axis_if ();
    axis_if out_axis_if ();

    for (genvar i = 0; i < `UDP_ARB_S_COUNT; i++) begin : g_src
        assign s_axis_if[i].tdata = s_axis_tdata[i];
        assign s_axis_if[i].tuser = s_axis_tuser[i];
        assign s_axis_if[i].tlast = s_axis_tlast[i];
        assign s_axis_if[i].tvalid = s_axis_tvalid[i];
        assign s_axis_tready[i] = s_axis_if[i].tready;
    end

    udp_arb_select u_select (
        .clk         (clk),
        .reset       (reset),
        .hdr_req     (s_hdr_valid),
        .frame_done  (frame_done),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    udp_arb_mux u_mux (
        .clk         (clk),
        .reset       (reset),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr_ready (s_hdr_ready),
        .s_hdr       (s_hdr),
        .s_axis      (s_axis_if),
        .m_hdr_valid (mux_hdr_valid),
        .m_hdr_ready (mux_hdr_ready),
        .m_hdr       (m_hdr),
        .m_axis      (mux_axis_if),
        .frame_done  (frame_done)
    );

    udp_axis_skid u_skid (
        .clk    (clk),
        .reset  (reset),
        .s_axis (mux_axis_if),
        .m_axis (out_axis_if)
    );

    // next header waits until the previous frame's tail has left the skid buffer
    assign m_hdr_valid = mux_hdr_valid && !out_axis_if.tvalid;
    assign mux_hdr_ready = m_hdr_ready && !out_axis_if.tvalid;

    assign m_axis_tdata = out_axis_if.tdata;
    assign m_axis_tuser = out_axis_if.tuser;
    assign m_axis_tlast = out_axis_if.tlast;
    assign m_axis_tvalid = out_axis_if.tvalid;
    assign out_axis_if.tready = m_axis_tready;

endmodule

`default_nettype wire

/* rtl/udp_tx_pkg.sv */
// shared types for the UDP transmit arbiter
// reduced UDP/IP transmit header and the source index type

`default_nettype none

`include "udp_arb_settings.svh"

package udp_tx_pkg;

    localparam int SRC_IDX_W = (`UDP_ARB_S_COUNT > 1) ? $clog2(`UDP_ARB_S_COUNT) : 1;

    typedef logic [SRC_IDX_W-1:0] src_idx_t;

    // fields a transmit engine needs, 144 bits
    typedef struct packed {
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [7:0]  ip_ttl;
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_tx_hdr_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module udp_tx_arb_tb -f sim.f > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/Vudp_tx_arb_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation passed" sim.log && exit 0 || exit 1

/* sim.f */
+incdir+include
rtl/udp_tx_pkg.sv
rtl/axis_if.sv
rtl/udp_arb_select.sv
rtl/udp_arb_mux.sv
rtl/udp_axis_skid.sv
rtl/udp_tx_arb_top.sv
verif/udp_tx_arb_assertions.sv
verif/udp_tx_arb_tb.sv

/* verif/udp_tx_arb_assertions.sv */
// handshake checks on the arbiter output ports
// header and payload hold until transfer, no header inside an open frame

`timescale 1ns/1ps
`default_nettype none

`include "udp_arb_settings.svh"

module udp_tx_arb_assertions (
    input var logic                           clk,
    input var logic                           reset,
    input var logic                           m_hdr_valid,
    input var logic                           m_hdr_ready,
    input var udp_tx_pkg::udp_tx_hdr_t        m_hdr,
    input var logic [`UDP_ARB_DATA_WIDTH-1:0] m_axis_tdata,
    input var logic [`UDP_ARB_USER_WIDTH-1:0] m_axis_tuser,
    input var logic                           m_axis_tlast,
    input var logic                           m_axis_tvalid,
    input var logic                           m_axis_tready
);
    logic frame_open;

    // open from the header transfer until the tlast beat leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_open <= 1'b0;
        end else if (m_hdr_valid && m_hdr_ready) begin
            frame_open <= 1'b1;
        end else if (m_axis_tvalid && m_axis_tready && m_axis_tlast) begin
            frame_open <= 1'b0;
        end
    end

    hdr_hold: assert property (@(posedge clk) disable iff (reset)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_hdr))
        else $error("m_hdr_valid dropped or m_hdr changed before the transfer");

    payload_hold: assert property (@(posedge clk) disable iff (reset)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
            && $stable(m_axis_tuser) && $stable(m_axis_tlast))
        else $error("m_axis_tvalid dropped or payload changed before the transfer");

    no_hdr_in_frame: assert property (@(posedge clk) disable iff (reset)
        !(frame_open && m_hdr_valid))
        else $error("m_hdr_valid raised while a payload frame is partly sent");

endmodule

bind udp_tx_arb_top udp_tx_arb_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .m_hdr_valid   (m_hdr_valid),
    .m_hdr_ready   (m_hdr_ready),
    .m_hdr         (m_hdr),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
);

`default_nettype wire

/* verif/udp_tx_arb_tb.sv */
// testbench for the UDP transmit arbiter
// random frames per source, arbitration model and output frame checker

`timescale 1ns/1ps
`default_nettype none

`include "udp_arb_settings.svh"

module udp_tx_arb_tb;
    localparam int NS = `UDP_ARB_S_COUNT;
    localparam int DW = `UDP_ARB_DATA_WIDTH;
    localparam int UW = `UDP_ARB_USER_WIDTH;
    localparam int NF = 40;
    localparam int MAXLEN = 8;
    localparam int SEED = 24330;
    localparam int CLK_PERIOD = 10;
    localparam int TIMEOUT_CYCLES = NS * NF * 40;

    typedef logic [DW-1:0] data_t;
    typedef logic [UW-1:0] user_t;
    typedef struct packed {
        data_t data;
        user_t user;
        logic  last;
    } beat_t;

    logic                             clk;
    logic                             reset;
    logic [NS-1:0]                    s_hdr_valid;
    logic [NS-1:0]                    s_hdr_ready;
    udp_tx_pkg::udp_tx_hdr_t [NS-1:0] s_hdr;
    logic [NS-1:0][DW-1:0]            s_axis_tdata;
    logic [NS-1:0][UW-1:0]            s_axis_tuser;
    logic [NS-1:0]                    s_axis_tlast;
    logic [NS-1:0]                    s_axis_tvalid;
    logic [NS-1:0]                    s_axis_tready;
    logic                             m_hdr_valid;
    logic                             m_hdr_ready;
    udp_tx_pkg::udp_tx_hdr_t          m_hdr;
    data_t                            m_axis_tdata;
    user_t                            m_axis_tuser;
    logic                             m_axis_tlast;
    logic                             m_axis_tvalid;
    logic                             m_axis_tready;

    // generated frames, offered in index order on each source
    udp_tx_pkg::udp_tx_hdr_t f_hdr [NS][NF];
    data_t                   f_data [NS][NF][MAXLEN];
    user_t                   f_user [NS][NF];
    int                      f_len [NS][NF];

    int            fi [NS];
    int            bi [NS];
    logic [NS-1:0] in_pay;
    logic [NS-1:0] hdr_xfer;
    logic [NS-1:0] pay_xfer;

    logic  model_busy;
    int    model_grant;
    beat_t exp_q [$];
    int    frames_out;
    int    bytes_out;
    int    total_bytes;
    int    hdr_errors;
    int    pay_errors;
    int    order_errors;
    int    count_errors;

    udp_tx_arb_top DUT (
        .clk           (clk),
        .reset         (reset),
        .s_hdr_valid   (s_hdr_valid),
        .s_hdr_ready   (s_hdr_ready),
        .s_hdr         (s_hdr),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_hdr_valid   (m_hdr_valid),
        .m_hdr_ready   (m_hdr_ready),
        .m_hdr         (m_hdr),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, %0d of %0d frames out", TIMEOUT_CYCLES,
            frames_out, NS * NF);
        $display("Simulation failed");
        $finish;
    end

    task gen_frames();
        logic [159:0] raw;
        for (int s = 0; s < NS; s++) begin
            for (int k = 0; k < NF; k++) begin
                for (int w = 0; w < 5; w++) begin
                    raw[w*32 +: 32] = $urandom;
                end
                f_hdr[s][k] = raw[143:0];
                f_len[s][k] = 1 + $urandom_range(MAXLEN - 1, 0);
                f_user[s][k] = user_t'($urandom);
                for (int b = 0; b < MAXLEN; b++) begin
                    f_data[s][k][b] = data_t'($urandom);
                end
                total_bytes += f_len[s][k];
            end
        end
    endtask

    // round-robin searches after the last winner, fixed priority from source 0
    function automatic int predict_winner(input logic [NS-1:0] req, input int last);
        int winner;
        int c;
        winner = -1;
        for (int i = 1; i <= NS; i++) begin
            c = (`UDP_ARB_ROUND_ROBIN != 0) ? (last + i) % NS : i - 1;
            if (req[c] && winner < 0) begin
                winner = c;
            end
        end
        return winner;
    endfunction

    // advance each source past last cycle's transfers, then offer at random
    task drive_sources();
        int k;
        for (int s = 0; s < NS; s++) begin
            if (hdr_xfer[s]) begin
                s_hdr_valid[s] = 1'b0;
                in_pay[s] = 1'b1;
                bi[s] = 0;
            end
            if (pay_xfer[s]) begin
                s_axis_tvalid[s] = 1'b0;
                if (s_axis_tlast[s]) begin
                    in_pay[s] = 1'b0;
                    fi[s]++;
                end else begin
                    bi[s]++;
                end
            end
            k = fi[s];
            if (!in_pay[s] && !s_hdr_valid[s] && k < NF && $urandom_range(3, 0) != 0) begin
                s_hdr_valid[s] = 1'b1;
                s_hdr[s] = f_hdr[s][k];
            end
            if (in_pay[s] && !s_axis_tvalid[s] && $urandom_range(3, 0) != 0) begin
                s_axis_tvalid[s] = 1'b1;
                s_axis_tdata[s] = f_data[s][k][bi[s]];
                s_axis_tuser[s] = f_user[s][k];
                s_axis_tlast[s] = (bi[s] == f_len[s][k] - 1);
            end
        end
    endtask

    task check_header();
        udp_tx_pkg::udp_tx_hdr_t exp_hdr;
        beat_t                   beat;
        int                      s;
        int                      k;
        assert (exp_q.size() == 0) else begin
            $display("header sent with %0d beats of the previous frame pending", exp_q.size());
            order_errors++;
        end
        assert (model_busy && hdr_xfer[model_grant]) else begin
            $display("output header does not come from predicted source %0d", model_grant);
            order_errors++;
        end
        if (model_busy && fi[model_grant] < NF) begin
            s = model_grant;
            k = fi[s];
            exp_hdr = f_hdr[s][k];
            assert (m_hdr == exp_hdr) else begin
                $display("FAIL m_hdr got 0x%h expected 0x%h", m_hdr, exp_hdr);
                hdr_errors++;
            end
            for (int b = 0; b < f_len[s][k]; b++) begin
                beat.data = f_data[s][k][b];
                beat.user = f_user[s][k];
                beat.last = (b == f_len[s][k] - 1);
                exp_q.push_back(beat);
            end
        end
    endtask

    task check_beat();
        beat_t exp;
        assert (exp_q.size() != 0) else begin
            $display("payload beat on the output with no frame open");
            order_errors++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            assert (m_axis_tdata == exp.data) else begin
                $display("FAIL m_axis_tdata got 0x%h expected 0x%h", m_axis_tdata, exp.data);
                pay_errors++;
            end
            assert (m_axis_tuser == exp.user) else begin
                $display("FAIL m_axis_tuser got 0x%h expected 0x%h", m_axis_tuser, exp.user);
                pay_errors++;
            end
            assert (m_axis_tlast == exp.last) else begin
                $display("FAIL m_axis_tlast got 0x%h expected 0x%h", m_axis_tlast, exp.last);
                pay_errors++;
            end
            bytes_out++;
            if (exp.last) begin
                frames_out++;
            end
        end
    endtask

    // inputs are settled here, so these are the transfers of the coming edge
    task observe();
        hdr_xfer = s_hdr_valid & s_hdr_ready;
        pay_xfer = s_axis_tvalid & s_axis_tready;
        for (int s = 0; s < NS; s++) begin
            assert (!hdr_xfer[s] || (model_busy && s == model_grant)) else begin
                $display("source %0d header accepted while source %0d is granted", s,
                    model_grant);
                order_errors++;
            end
            assert (!pay_xfer[s] || (model_busy && s == model_grant)) else begin
                $display("source %0d payload accepted while source %0d is granted", s,
                    model_grant);
                order_errors++;
            end
        end
        if (m_hdr_valid && m_hdr_ready) begin
            check_header();
        end
        if (m_axis_tvalid && m_axis_tready) begin
            check_beat();
        end
        if (!model_busy) begin
            if (|s_hdr_valid) begin
                model_grant = predict_winner(s_hdr_valid, model_grant);
                model_busy = 1'b1;
            end
        end else if (pay_xfer[model_grant] && s_axis_tlast[model_grant]) begin
            model_busy = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        s_hdr_valid = '0;
        s_hdr = '0;
        s_axis_tdata = '0;
        s_axis_tuser = '0;
        s_axis_tlast = '0;
        s_axis_tvalid = '0;
        m_hdr_ready = 1'b0;
        m_axis_tready = 1'b0;
        in_pay = '0;
        hdr_xfer = '0;
        pay_xfer = '0;
        fi = '{default: 0};
        bi = '{default: 0};
        model_busy = 1'b0;
        model_grant = NS - 1;
        frames_out = 0;
        bytes_out = 0;
        total_bytes = 0;
        hdr_errors = 0;
        pay_errors = 0;
        order_errors = 0;
        count_errors = 0;
        gen_frames();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // nothing offered yet
        repeat (5) begin
            @(negedge clk);
            #2;
            assert (!m_hdr_valid) else begin
                $display("FAIL m_hdr_valid got 0x%h expected 0x0", m_hdr_valid);
                order_errors++;
            end
            assert (!m_axis_tvalid) else begin
                $display("FAIL m_axis_tvalid got 0x%h expected 0x0", m_axis_tvalid);
                order_errors++;
            end
        end
        while (frames_out < NS * NF) begin
            @(negedge clk);
            drive_sources();
            m_hdr_ready = ($urandom_range(3, 0) != 0);
            m_axis_tready = ($urandom_range(3, 0) != 0);
            #2;
            observe();
        end
        assert (bytes_out == total_bytes) else begin
            $display("%0d bytes left the arbiter but %0d were generated", bytes_out,
                total_bytes);
            count_errors++;
        end
        $display("errors: header %0d, payload %0d, order %0d, count %0d; frames %0d, bytes %0d",
            hdr_errors, pay_errors, order_errors, count_errors, frames_out, bytes_out);
        if (hdr_errors + pay_errors + order_errors + count_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
